// ==== bench/idt_subsystem_asserts.sv ====
`timescale 1ns/1ps

module idt_subsystem_asserts (
	input logic         iCLOCK,
	input logic         inRESET,
	input logic         reset_sync,
	input logic         mem_req_valid,
	input logic         mem_req_ready,
	input logic [31:0]  mem_req_addr,
	input logic         done,
	input logic         irq_valid,
	input logic         irq_ready,
	input logic [7:0]   irq_evt,
	input logic         loading,
	input logic [255:0] conf_all
);
	// Request held with a steady address until accepted
	req_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
		else $error("mem request dropped or changed before acceptance");

	done_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		done |=> !done)
		else $error("done high for more than one cycle");

	irq_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		irq_valid && !irq_ready |=> irq_valid && $stable(irq_evt))
		else $error("irq event changed before irq_ready");

	// Table contents only move after a load cycle or a soft reset
	table_quiet: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!$stable(conf_all) |-> $past(loading) || $past(reset_sync))
		else $error("table changed while not loading");

endmodule

bind idt_subsystem idt_subsystem_asserts asserts_i (
	.iCLOCK        (iCLOCK),
	.inRESET       (inRESET),
	.reset_sync    (reset_sync),
	.mem_req_valid (mem_req_valid),
	.mem_req_ready (mem_req_ready),
	.mem_req_addr  (mem_req_addr),
	.done          (done),
	.irq_valid     (irq_valid),
	.irq_ready     (irq_ready),
	.irq_evt       (irq_evt),
	.loading       (loading),
	.conf_all      (conf_all)
);

// ==== bench/tb_idt_subsystem.sv ====
`timescale 1ns/1ps
`include "idt_consts.svh"

module tb_idt_subsystem;
	import idt_pkg::*;

	localparam mem_word_t IDTR_A = 32'h0001_0000;
	localparam mem_word_t IDTR_B = 32'h0002_0400;
	localparam int NROWS = 10;
	localparam int WAIT_LIMIT = 2000;

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	logic start;
	mem_word_t idtr;
	logic done;
	logic mem_req_valid;
	logic mem_req_ready;
	mem_word_t mem_req_addr;
	logic mem_rsp_valid;
	logic mem_rsp_ready;
	mem_word_t mem_rsp_data;
	logic [`IDT_ENTRIES-1:0] irq_req;
	logic irq_valid;
	logic irq_ready;
	idt_index_t irq_entry;
	irq_level_t irq_level;
	logic overflow;

	integer seed;
	int value_errors;
	int timeout_errors;
	mem_word_t fill [`IDT_ENTRIES];
	int req_count;
	int rsp_q[$];
	int rsp_delay;
	logic rsp_fire;

	// Request vector, hit flag, expected entry and level per row
	logic [`IDT_ENTRIES-1:0] row_req [NROWS];
	logic row_hit [NROWS];
	idt_index_t row_entry [NROWS];
	irq_level_t row_level [NROWS];

	idt_subsystem idt_subsystem_i (.*);

	always #2 iCLOCK = ~iCLOCK;

	// Rule fields of entry i laid over its random fill word
	function automatic mem_word_t descriptor(input int i);
		mem_word_t w;
		w = fill[i];
		w[`IDT_BIT_VALID] = (i % 3) != 0;
		w[`IDT_BIT_MASK] = (i % 5) == 0;
		w[`IDT_LEVEL_LSB +: 2] = 2'(i % 4);
		return w;
	endfunction

	task automatic check_event(input irq_event_t got, input irq_event_t exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %0t: %s got entry %0d level %0d, expected entry %0d level %0d",
				$time, what, got.entry, got.level, exp.entry, exp.level);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input mem_word_t got, input mem_word_t exp, input string what);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// In-order memory model with a random response delay
	always @(negedge iCLOCK) begin
		if (!inRESET || reset_sync) begin
			rsp_q.delete();
			mem_rsp_valid = 1'b0;
			mem_req_ready = 1'b0;
			rsp_fire = 1'b0;
			rsp_delay = 0;
			req_count = 0;
		end else begin
			if (rsp_fire) begin
				void'(rsp_q.pop_front());
				mem_rsp_valid = 1'b0;
			end
			if (!mem_rsp_valid && rsp_q.size() > 0) begin
				if (rsp_delay == 0) begin
					mem_rsp_valid = 1'b1;
					mem_rsp_data = descriptor(rsp_q[0]);
					rsp_delay = $unsigned($random(seed)) % 4;
				end else begin
					rsp_delay--;
				end
			end
			rsp_fire = mem_rsp_valid && mem_rsp_ready;
			mem_req_ready = ($unsigned($random(seed)) % 4) != 0;
			if (mem_req_valid && mem_req_ready) begin
				check_word(mem_req_addr, idtr + mem_word_t'(req_count << 3), "request address");
				rsp_q.push_back(req_count);
				req_count++;
			end
		end
	end

	task automatic run_load(input mem_word_t base);
		int cycles;
		@(negedge iCLOCK);
		idtr = base;
		req_count = 0;
		start = 1'b1;
		@(negedge iCLOCK);
		start = 1'b0;
		irq_req = '1;
		cycles = 0;
		while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
			check_flag(irq_valid, 1'b0, "irq_valid during load");
			@(negedge iCLOCK);
			cycles++;
		end
		irq_req = '0;
		if (cycles >= WAIT_LIMIT) begin
			timeout_errors++;
			$display("Timeout: the descriptor load never raised done");
		end else begin
			check_flag(req_count == `IDT_ENTRIES, 1'b1, "exactly 64 reads before done");
			@(negedge iCLOCK);
			check_flag(done, 1'b0, "done after its pulse");
			check_flag(irq_valid, 1'b0, "irq_valid after load");
		end
	endtask

	task automatic apply_row(input int r, input logic loaded);
		int cycles;
		irq_event_t exp;
		irq_req = row_req[r];
		@(negedge iCLOCK);
		irq_req = '0;
		cycles = 1;
		if (row_hit[r] && loaded) begin
			while (irq_valid !== 1'b1 && cycles < 8) begin
				@(negedge iCLOCK);
				cycles++;
			end
			if (irq_valid !== 1'b1) begin
				timeout_errors++;
				$display("Timeout: no event came out for row %0d", r);
			end else begin
				check_flag(cycles == 1, 1'b1, "event one cycle after request");
				exp.entry = row_entry[r];
				exp.level = row_level[r];
				check_event({irq_entry, irq_level}, exp, $sformatf("row %0d", r));
				@(negedge iCLOCK);
				check_flag(irq_valid, 1'b0, "single event per row");
			end
		end else begin
			for (int c = 0; c < 4; c++) begin
				check_flag(irq_valid, 1'b0, $sformatf("no event for row %0d", r));
				@(negedge iCLOCK);
			end
		end
	endtask

	task automatic overflow_test();
		idt_index_t ents [5];
		irq_level_t lvls [5];
		irq_event_t exp;
		ents = '{6'd1, 6'd2, 6'd4, 6'd7, 6'd11};
		lvls = '{2'd1, 2'd2, 2'd0, 2'd3, 2'd3};
		irq_ready = 1'b0;
		for (int k = 0; k < 5; k++) begin
			check_flag(overflow, 1'b0, "overflow before fifth event");
			irq_req = '0;
			irq_req[ents[k]] = 1'b1;
			@(negedge iCLOCK);
		end
		irq_req = '0;
		check_flag(overflow, 1'b1, "overflow after fifth event");
		irq_ready = 1'b1;
		for (int k = 0; k < 4; k++) begin
			exp.entry = ents[k];
			exp.level = lvls[k];
			check_flag(irq_valid, 1'b1, "irq_valid while draining");
			check_event({irq_entry, irq_level}, exp, $sformatf("drained event %0d", k));
			@(negedge iCLOCK);
		end
		check_flag(irq_valid, 1'b0, "queue empty after drain");
		check_flag(overflow, 1'b1, "overflow stays set");
	endtask

	initial begin
		int cycles;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		reset_sync = 1'b0;
		start = 1'b0;
		idtr = '0;
		irq_req = '0;
		irq_ready = 1'b1;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_data = '0;
		seed = 32'ha5a3;
		value_errors = 0;
		timeout_errors = 0;
		for (int i = 0; i < `IDT_ENTRIES; i++) begin
			fill[i] = $random(seed);
		end
		// Worked out from the image rule and the priority rule
		row_req = '{64'h2, 64'h80, 64'h4000_0000_0000_0000, 64'h16, 64'h884,
			64'h88_4000, 64'h29, 64'h8000_0000_0000_8400, 64'h2010,
			64'h2000_0000_0040_4000};
		row_hit = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
		row_entry = '{6'd1, 6'd7, 6'd62, 6'd2, 6'd7, 6'd19, 6'd0, 6'd0, 6'd13, 6'd14};
		row_level = '{2'd1, 2'd3, 2'd2, 2'd2, 2'd3, 2'd3, 2'd0, 2'd0, 2'd1, 2'd2};

		repeat (5) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);

		run_load(IDTR_A);
		for (int r = 0; r < NROWS; r++) begin
			apply_row(r, 1'b1);
		end
		overflow_test();

		// One event left waiting in the queue
		irq_ready = 1'b0;
		irq_req[1] = 1'b1;
		@(negedge iCLOCK);
		irq_req = '0;
		check_flag(irq_valid, 1'b1, "event parked before the aborted load");

		// Abort a load partway through
		idtr = IDTR_B;
		req_count = 0;
		start = 1'b1;
		@(negedge iCLOCK);
		start = 1'b0;
		cycles = 0;
		while (req_count < 20 && cycles < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			cycles++;
		end
		if (cycles >= WAIT_LIMIT) begin
			timeout_errors++;
			$display("Timeout: the second load issued too few reads");
		end
		reset_sync = 1'b1;
		repeat (2) @(negedge iCLOCK);
		reset_sync = 1'b0;
		check_flag(done, 1'b0, "done after reset_sync");
		check_flag(idt_subsystem_i.loading, 1'b0, "loading after reset_sync");
		check_flag(overflow, 1'b0, "overflow after reset_sync");
		check_flag(irq_valid, 1'b0, "irq_valid after reset_sync");
		irq_ready = 1'b1;
		apply_row(0, 1'b0);
		apply_row(1, 1'b0);

		run_load(IDTR_B);
		for (int r = 0; r < NROWS; r++) begin
			apply_row(r, 1'b1);
		end

		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/idt_pkg.sv
rtl/sync_fifo.sv
rtl/idt_loader.sv
rtl/irq_config_table.sv
rtl/irq_priority_select.sv
rtl/idt_subsystem.sv
bench/idt_subsystem_asserts.sv
bench/tb_idt_subsystem.sv

// ==== rtl/idt_consts.svh ====
`ifndef IDT_CONSTS_SVH
`define IDT_CONSTS_SVH

// Descriptor table geometry
`define IDT_ENTRIES 64
`define IDT_STRIDE_SHIFT 3

// Field positions in the first descriptor word
`define IDT_BIT_VALID 0
`define IDT_BIT_MASK 1
`define IDT_LEVEL_LSB 16

// Queue depths
`define IDT_RSP_DEPTH 4
`define IRQ_EVT_DEPTH 4

`endif

// ==== rtl/idt_loader.sv ====
`timescale 1ns/1ps
`include "idt_consts.svh"

module idt_loader
	import idt_pkg::*;
(
	input  logic       iCLOCK,
	input  logic       inRESET,
	input  logic       reset_sync,
	input  logic       start,
	input  mem_word_t  idtr,
	output logic       done,
	output logic       loading,
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output mem_word_t  mem_req_addr,
	input  logic       rsp_valid,
	output logic       rsp_ready,
	input  mem_word_t  rsp_data,
	output logic       wr_en,
	output idt_index_t wr_index,
	output irq_conf_t  wr_conf
);
	typedef enum logic {
		IDLE,
		LOAD
	} state_t;

	localparam logic [6:0] LAST = 7'(`IDT_ENTRIES);
	localparam logic [6:0] MAX_OUTSTANDING = 7'(`IDT_RSP_DEPTH);

	state_t state;
	logic [6:0] iss_cnt;
	logic [6:0] rcv_cnt;
	logic [6:0] outstanding;
	logic req_fire;
	logic rsp_pop;
	logic done_q;

	assign loading = (state == LOAD);
	assign done = done_q;

	// Reads in flight or parked in the response FIFO
	assign outstanding = iss_cnt - rcv_cnt;

	// Held steady while waiting since outstanding can only shrink
	assign mem_req_valid = loading && (iss_cnt < LAST) && (outstanding < MAX_OUTSTANDING);
	assign mem_req_addr = idtr + (mem_word_t'(iss_cnt) << `IDT_STRIDE_SHIFT);
	assign req_fire = mem_req_valid && mem_req_ready;

	assign rsp_ready = loading && (rcv_cnt < LAST);
	assign rsp_pop = rsp_valid && rsp_ready;

	// Descriptor word sliced straight into the table write
	assign wr_en = rsp_pop;
	assign wr_index = idt_index_t'(rcv_cnt);
	assign wr_conf.valid = rsp_data[`IDT_BIT_VALID];
	assign wr_conf.mask = rsp_data[`IDT_BIT_MASK];
	assign wr_conf.level = rsp_data[`IDT_LEVEL_LSB +: $bits(irq_level_t)];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			iss_cnt <= '0;
			rcv_cnt <= '0;
			done_q <= 1'b0;
		end else if (reset_sync) begin
			state <= IDLE;
			iss_cnt <= '0;
			rcv_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					done_q <= 1'b0;
					if (start) begin
						state <= LOAD;
						iss_cnt <= '0;
						rcv_cnt <= '0;
					end
				end
				LOAD: begin
					if (req_fire) begin
						iss_cnt <= iss_cnt + 7'd1;
					end
					if (rsp_pop) begin
						rcv_cnt <= rcv_cnt + 7'd1;
					end
					// Last entry written on the previous edge
					if (rcv_cnt == LAST) begin
						state <= IDLE;
						done_q <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== rtl/idt_pkg.sv ====
`include "idt_consts.svh"

package idt_pkg;

	// Table index, wide enough for every entry
	typedef logic [$clog2(`IDT_ENTRIES)-1:0] idt_index_t;

	// Priority level, 3 is the highest
	typedef logic [1:0] irq_level_t;

	// Data and address word of the load port
	typedef logic [31:0] mem_word_t;

	// Per-entry interrupt configuration
	typedef struct packed {
		logic       valid;
		logic       mask;
		irq_level_t level;
	} irq_conf_t;

	// Event handed to the pipeline
	typedef struct packed {
		idt_index_t entry;
		irq_level_t level;
	} irq_event_t;

endpackage

// ==== rtl/idt_subsystem.sv ====
`timescale 1ns/1ps
`include "idt_consts.svh"

module idt_subsystem
	import idt_pkg::*;
(
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    reset_sync,
	input  logic                    start,
	input  mem_word_t               idtr,
	output logic                    done,
	output logic                    mem_req_valid,
	input  logic                    mem_req_ready,
	output mem_word_t               mem_req_addr,
	input  logic                    mem_rsp_valid,
	output logic                    mem_rsp_ready,
	input  mem_word_t               mem_rsp_data,
	input  logic [`IDT_ENTRIES-1:0] irq_req,
	output logic                    irq_valid,
	input  logic                    irq_ready,
	output idt_index_t              irq_entry,
	output irq_level_t              irq_level,
	output logic                    overflow
);
	logic loading;

	// Response FIFO to loader
	logic rsp_valid;
	logic rsp_ready;
	mem_word_t rsp_data;

	// Loader to table
	logic wr_en;
	idt_index_t wr_index;
	irq_conf_t wr_conf;

	irq_conf_t [`IDT_ENTRIES-1:0] conf_all;

	// Selector to event FIFO
	logic evt_valid;
	logic evt_ready;
	irq_event_t evt_data;
	irq_event_t irq_evt;

	assign irq_entry = irq_evt.entry;
	assign irq_level = irq_evt.level;

	idt_loader loader_i (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.reset_sync    (reset_sync),
		.start         (start),
		.idtr          (idtr),
		.done          (done),
		.loading       (loading),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req_addr  (mem_req_addr),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.rsp_data      (rsp_data),
		.wr_en         (wr_en),
		.wr_index      (wr_index),
		.wr_conf       (wr_conf)
	);

	sync_fifo #(
		.T     (mem_word_t),
		.DEPTH (`IDT_RSP_DEPTH)
	) rsp_fifo_i (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.in_valid   (mem_rsp_valid),
		.in_ready   (mem_rsp_ready),
		.in_data    (mem_rsp_data),
		.out_valid  (rsp_valid),
		.out_ready  (rsp_ready),
		.out_data   (rsp_data)
	);

	irq_config_table table_i (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.wr_en      (wr_en),
		.wr_index   (wr_index),
		.wr_conf    (wr_conf),
		.conf_all   (conf_all)
	);

	irq_priority_select select_i (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.irq_req    (irq_req),
		.loading    (loading),
		.conf_all   (conf_all),
		.evt_valid  (evt_valid),
		.evt_ready  (evt_ready),
		.evt_data   (evt_data),
		.overflow   (overflow)
	);

	sync_fifo #(
		.T     (irq_event_t),
		.DEPTH (`IRQ_EVT_DEPTH)
	) evt_fifo_i (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.in_valid   (evt_valid),
		.in_ready   (evt_ready),
		.in_data    (evt_data),
		.out_valid  (irq_valid),
		.out_ready  (irq_ready),
		.out_data   (irq_evt)
	);

endmodule

// ==== rtl/irq_config_table.sv ====
`timescale 1ns/1ps
`include "idt_consts.svh"

module irq_config_table
	import idt_pkg::*;
(
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          reset_sync,
	input  logic                          wr_en,
	input  idt_index_t                    wr_index,
	input  irq_conf_t                     wr_conf,
	output irq_conf_t [`IDT_ENTRIES-1:0]  conf_all
);
	irq_conf_t [`IDT_ENTRIES-1:0] entries_q;
	logic [`IDT_ENTRIES-1:0] wr_sel;

	// One-hot write select
	always_comb begin
		wr_sel = '0;
		if (wr_en) begin
			wr_sel[wr_index] = 1'b1;
		end
	end

	// Every entry comes out of reset as invalid
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entries_q <= '0;
		end else if (reset_sync) begin
			entries_q <= '0;
		end else begin
			for (int i = 0; i < `IDT_ENTRIES; i++) begin
				if (wr_sel[i]) begin
					entries_q[i] <= wr_conf;
				end
			end
		end
	end

	// Whole table visible to the selector
	assign conf_all = entries_q;

endmodule

// ==== rtl/irq_priority_select.sv ====
`timescale 1ns/1ps
`include "idt_consts.svh"

module irq_priority_select
	import idt_pkg::*;
(
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          reset_sync,
	input  logic [`IDT_ENTRIES-1:0]       irq_req,
	input  logic                          loading,
	input  irq_conf_t [`IDT_ENTRIES-1:0]  conf_all,
	output logic                          evt_valid,
	input  logic                          evt_ready,
	output irq_event_t                    evt_data,
	output logic                          overflow
);
	logic [`IDT_ENTRIES-1:0] cand;
	logic found;
	idt_index_t best_idx;
	irq_level_t best_lvl;
	logic overflow_q;

	// Requested, valid and not masked
	always_comb begin
		for (int i = 0; i < `IDT_ENTRIES; i++) begin
			cand[i] = irq_req[i] && conf_all[i].valid && !conf_all[i].mask;
		end
	end

	// Ascending scan with a strict compare keeps the lowest index on a tie
	always_comb begin
		found = 1'b0;
		best_idx = '0;
		best_lvl = '0;
		for (int i = 0; i < `IDT_ENTRIES; i++) begin
			if (cand[i] && (!found || (conf_all[i].level > best_lvl))) begin
				found = 1'b1;
				best_idx = idt_index_t'(i);
				best_lvl = conf_all[i].level;
			end
		end
	end

	// Table contents are not trusted mid-load
	assign evt_valid = found && !loading;
	assign evt_data.entry = best_idx;
	assign evt_data.level = best_lvl;
	assign overflow = overflow_q;

	// Sticky until reset
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			overflow_q <= 1'b0;
		end else if (reset_sync) begin
			overflow_q <= 1'b0;
		end else if (evt_valid && !evt_ready) begin
			overflow_q <= 1'b1;
		end
	end

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic reset_sync,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count < CW'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	// Storage, no reset needed
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (reset_sync) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_idt_subsystem -o sim_idt

./obj_dir/sim_idt > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
	exit 0
else
	exit 1
fi
